//--- hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // ============================================================
  // CPU side of the bus
  // ============================================================

  localparam int ROM_ADDR_BITS = 22;  // 8-bit slot above 14-bit offset

  // One CPU bus cycle as seen by the slave
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        is_io;   // I/O cycle, else memory
    logic        write;
  } bus_req_t;

  // Decoded target of a bus cycle
  typedef enum logic [3:0] {
    vdp_data,
    vdp_ctrl,
    psg,          // Write only
    v_count,
    h_count,
    joy0,
    joy1,
    mem_ctrl,
    joy_ctrl,
    mem_slot_reg, // FFFC..FFFF writes
    mem_plain
  } io_port_e;

  // Where a memory read would be served from
  typedef enum logic [1:0] {
    bios,
    cart,
    ram
  } mem_src_e;

  // ============================================================
  // Internal pipeline and reply
  // ============================================================

  typedef struct packed {
    io_port_e    port;
    logic        write;
    logic [7:0]  wdata;
    logic [15:0] addr;
  } dec_op_t;

  typedef struct packed {
    logic [7:0]               data;
    logic [ROM_ADDR_BITS-1:0] rom_addr;
    mem_src_e                 src;
  } bus_rsp_t;

endpackage

`default_nettype wire

//--- hw/vdp_pkg.sv
`default_nettype none

package vdp_pkg;

  // ============================================================
  // Register file
  // ============================================================

  localparam int VDP_REG_COUNT = 11;

  typedef logic [7:0] vdp_reg_t;

  // Display mode resolved by priority from M1..M4
  typedef enum logic [2:0] {
    graphic0 = 3'd0,
    mode1    = 3'd1,
    graphic2 = 3'd2,
    mode3    = 3'd3,
    mode4    = 3'd4
  } vdp_mode_e;

  // Decoded configuration handed to the video side
  typedef struct packed {
    vdp_mode_e   mode;
    logic [13:0] name_base;
    logic [13:0] color_base;
    logic [13:0] pattern_base;
    logic [13:0] sprite_attr_base;
    logic [13:0] sprite_pattern_base;
    logic        display_en;      // reg1 bit 6
    logic        frame_irq_en;    // reg1 bit 5
    logic [7:0]  x_scroll;
    logic [7:0]  y_scroll;
  } vdp_cfg_t;

  // ============================================================
  // Video-side inputs
  // ============================================================

  // Pulses and live state from the renderer
  typedef struct packed {
    logic       frame_irq;
    logic       sprite_collision;
    logic       too_many_sprites;
    logic [4:0] spritex;          // Sprite number on overflow
  } vdp_event_t;

  typedef struct packed {
    logic [7:0] v;
    logic [7:0] h;
  } beam_t;

  // Active-high buttons that the port inverts
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic b1;
    logic b2;
  } joy_buttons_t;

endpackage

`default_nettype wire

//--- hw/port_decode.sv
`timescale 1ns/100ps
`default_nettype none

module port_decode import bus_pkg::*; (
  input  wire           i_cpuClock,
  input  wire           i_n_hard_reset,
  input  wire bus_req_t i_req,
  input  wire           i_req_valid,
  output logic          o_req_ready,
  output dec_op_t       o_op,
  output logic          o_op_valid,
  input  wire           i_op_ready
);

  dec_op_t op_next;

  // Stage is free when empty or draining this cycle
  assign o_req_ready = !o_op_valid || i_op_ready;

  // ============================================================
  // Classify the request
  // ============================================================
  always_comb begin
    op_next.write = i_req.write;
    op_next.wdata = i_req.wdata;
    op_next.addr  = i_req.addr;
    if (i_req.is_io) begin
      // Only A7, A6 and A0 take part on the I/O side
      case ({i_req.addr[7:6], i_req.addr[0]})
        3'b000:  op_next.port = mem_ctrl;
        3'b001:  op_next.port = joy_ctrl;
        3'b010:  op_next.port = v_count;
        3'b011:  op_next.port = i_req.write ? psg : h_count;
        3'b100:  op_next.port = vdp_data;
        3'b101:  op_next.port = vdp_ctrl;
        3'b110:  op_next.port = joy0;
        default: op_next.port = joy1;
      endcase
    end else if (i_req.write && i_req.addr[15:2] == 14'h3fff) begin
      op_next.port = mem_slot_reg;                // FFFC..FFFF
    end else begin
      op_next.port = mem_plain;
    end
  end

  always_ff @(posedge i_cpuClock) begin
    if (!i_n_hard_reset) begin
      o_op_valid <= 1'b0;
    end else if (o_req_ready) begin
      o_op_valid <= i_req_valid;
    end
  end

  // Payload only moves with an accepted request
  always_ff @(posedge i_cpuClock) begin
    if (i_req_valid && o_req_ready) o_op <= op_next;
  end

  // A stalled op is held unchanged for the execute stage
  a_op_held: assert property (@(posedge i_cpuClock) disable iff (!i_n_hard_reset)
    o_op_valid && !i_op_ready |=> o_op_valid && $stable(o_op));

endmodule

`default_nettype wire

//--- hw/vdp_control.sv
`timescale 1ns/100ps
`default_nettype none

module vdp_control import bus_pkg::*; import vdp_pkg::*; #(
  parameter int VRAM_ADDR_BITS = 14
) (
  input  wire           i_cpuClock,
  input  wire           i_n_hard_reset,
  input  wire dec_op_t  i_op,
  input  wire           i_fire,
  output logic [7:0]    o_data_rd,
  output vdp_cfg_t      o_cfg
);

  logic                      second_byte;   // Next ctrl write is byte two
  logic [7:0]                first_byte;
  logic [VRAM_ADDR_BITS-1:0] vaddr;
  logic                      cram_sel;
  vdp_reg_t                  regs [VDP_REG_COUNT];
  logic [7:0]                vram [2**VRAM_ADDR_BITS];
  logic [7:0]                cram [64];

  logic       ctrl_wr, ctrl_rd, data_wr, data_rd;
  logic [1:0] code;
  logic [3:0] reg_idx;
  logic       reg_we, vram_load;
  logic [13:0] vram_addr_full;

  assign ctrl_wr = i_fire && i_op.port == vdp_ctrl && i_op.write;
  assign ctrl_rd = i_fire && i_op.port == vdp_ctrl && !i_op.write;
  assign data_wr = i_fire && i_op.port == vdp_data && i_op.write;
  assign data_rd = i_fire && i_op.port == vdp_data && !i_op.write;

  assign code           = i_op.wdata[7:6];
  assign reg_idx        = i_op.wdata[3:0];
  assign reg_we         = ctrl_wr && second_byte && code == 2'b10 && reg_idx < VDP_REG_COUNT;
  assign vram_load      = ctrl_wr && second_byte && !code[1];  // Bit 6 is ignored
  assign vram_addr_full = {i_op.wdata[5:0], first_byte};

  // ============================================================
  // Control port sequencing
  // ============================================================
  always_ff @(posedge i_cpuClock) begin
    if (!i_n_hard_reset) begin
      second_byte <= 1'b0;
      cram_sel    <= 1'b0;
      vaddr       <= '0;
      for (int i = 0; i < VDP_REG_COUNT; i++) regs[i] <= '0;
    end else if (ctrl_wr) begin
      second_byte <= !second_byte;
      if (reg_we) begin
        regs[reg_idx] <= first_byte;
      end else if (vram_load) begin
        vaddr    <= VRAM_ADDR_BITS'(vram_addr_full);
        cram_sel <= 1'b0;
      end else if (second_byte) begin
        // 11, or 10 with an index past the register file
        vaddr    <= VRAM_ADDR_BITS'(first_byte[5:0]);
        cram_sel <= 1'b1;
      end
    end else if (ctrl_rd || data_wr || data_rd) begin
      second_byte <= 1'b0;
      if (data_wr || data_rd) vaddr <= vaddr + 1'b1;  // Auto-increment
    end
  end

  always_ff @(posedge i_cpuClock) begin
    if (ctrl_wr && !second_byte) first_byte <= i_op.wdata;
  end

  // Video memories
  always_ff @(posedge i_cpuClock) begin
    if (data_wr && cram_sel) cram[vaddr[5:0]] <= i_op.wdata;
    if (data_wr && !cram_sel) vram[vaddr] <= i_op.wdata;
  end

  assign o_data_rd = cram_sel ? cram[vaddr[5:0]] : vram[vaddr];

  // ============================================================
  // Decoded configuration
  // ============================================================
  always_comb begin
    if (regs[0][2])      o_cfg.mode = mode4;
    else if (regs[1][3]) o_cfg.mode = mode3;
    else if (regs[0][1]) o_cfg.mode = graphic2;
    else if (regs[1][4]) o_cfg.mode = mode1;
    else                 o_cfg.mode = graphic0;

    o_cfg.name_base  = {regs[2][3:1], 11'b0};
    o_cfg.color_base = (o_cfg.mode == graphic2) ? {regs[3][7], 13'b0} : {regs[3], 6'b0};
    if (o_cfg.mode == mode4)         o_cfg.pattern_base = '0;
    else if (o_cfg.mode == graphic2) o_cfg.pattern_base = {regs[4][2], 13'b0};
    else                             o_cfg.pattern_base = {regs[4][2:0], 11'b0};
    o_cfg.sprite_attr_base    = {regs[5][6:1], 8'b0};
    o_cfg.sprite_pattern_base = (o_cfg.mode == mode4) ? {regs[6][2], 13'b0}
                                                      : {regs[6][2:0], 11'b0};
    o_cfg.display_en   = regs[1][6];
    o_cfg.frame_irq_en = regs[1][5];
    o_cfg.x_scroll     = regs[8];
    o_cfg.y_scroll     = regs[9];
  end

  // An index past the register file only reloads the CRAM address
  a_reg_idx: assert property (@(posedge i_cpuClock) disable iff (!i_n_hard_reset)
    ctrl_wr && second_byte && code == 2'b10 && reg_idx >= VDP_REG_COUNT
    |=> cram_sel && vaddr == $past(first_byte[5:0]));

endmodule

`default_nettype wire

//--- hw/mem_mapper.sv
`timescale 1ns/100ps
`default_nettype none

module mem_mapper import bus_pkg::*; (
  input  wire                      i_cpuClock,
  input  wire                      i_n_hard_reset,
  input  wire dec_op_t             i_op,
  input  wire                      i_fire,
  output logic [ROM_ADDR_BITS-1:0] o_rom_addr,
  output mem_src_e                 o_src
);

  logic [7:0] slot [3];     // Pages for regions 0..2
  logic [7:0] r_mem_ctrl;
  logic [7:0] mem_misc;     // Written through FFFC only
  logic [1:0] region;

  // ============================================================
  // Mapper registers
  // ============================================================
  always_ff @(posedge i_cpuClock) begin
    if (!i_n_hard_reset) begin
      slot[0]    <= 8'd0;
      slot[1]    <= 8'd1;
      slot[2]    <= 8'd2;
      r_mem_ctrl <= 8'hf7;   // BIOS enabled
      mem_misc   <= 8'h00;
    end else if (i_fire && i_op.write) begin
      if (i_op.port == mem_ctrl) begin
        r_mem_ctrl <= i_op.wdata;
      end else if (i_op.port == mem_slot_reg) begin
        case (i_op.addr[1:0])
          2'd0:    mem_misc <= i_op.wdata;
          2'd1:    slot[0]  <= i_op.wdata;
          2'd2:    slot[1]  <= i_op.wdata;
          default: slot[2]  <= i_op.wdata;
        endcase
      end
    end
  end

  // Address translation for the current op
  assign region = i_op.addr[15:14];

  always_comb begin
    if (region == 2'd3) begin
      o_rom_addr = ROM_ADDR_BITS'(i_op.addr);  // Work RAM passes through unmapped
      o_src      = ram;
    end else begin
      o_rom_addr = {slot[region], i_op.addr[13:0]};
      o_src      = r_mem_ctrl[3] ? cart : bios;
    end
  end

endmodule

`default_nettype wire

//--- hw/read_mux.sv
`timescale 1ns/100ps
`default_nettype none

module read_mux import bus_pkg::*; import vdp_pkg::*; (
  input  wire                       i_cpuClock,
  input  wire                       i_n_hard_reset,
  input  wire dec_op_t              i_op,
  input  wire                       i_op_valid,
  output logic                      o_op_ready,
  input  wire [7:0]                 i_vdp_data,
  input  wire [ROM_ADDR_BITS-1:0]   i_rom_addr,
  input  wire mem_src_e             i_src,
  input  wire vdp_event_t           i_events,
  input  wire beam_t                i_beam,
  input  wire joy_buttons_t         i_buttons,
  input  wire                       i_irq_en,
  output bus_rsp_t                  o_rsp,
  output logic                      o_rsp_valid,
  input  wire                       i_rsp_ready,
  output logic                      o_irq_pending,
  output logic                      o_fire
);

  logic     irq_flag, coll_flag;   // Sticky until status read
  logic     status_rd;
  logic     rsp_load;
  logic [7:0] status;
  logic [7:0] joy_data0;
  bus_rsp_t rsp_next;

  // Stall whenever a reply is held
  assign o_op_ready = !o_rsp_valid || i_rsp_ready;
  assign o_fire     = i_op_valid && o_op_ready;
  assign rsp_load   = o_fire && !i_op.write;
  assign status_rd  = o_fire && i_op.port == vdp_ctrl && !i_op.write;

  // ============================================================
  // Status flags
  // ============================================================
  always_ff @(posedge i_cpuClock) begin
    if (!i_n_hard_reset) begin
      irq_flag  <= 1'b0;
      coll_flag <= 1'b0;
    end else begin
      // A new pulse wins over the clearing read
      irq_flag  <= (irq_flag && !status_rd) || i_events.frame_irq;
      coll_flag <= (coll_flag && !status_rd) || i_events.sprite_collision;
    end
  end

  assign o_irq_pending = irq_flag && i_irq_en;

  assign status = {irq_flag, i_events.too_many_sprites, coll_flag,
                   i_events.too_many_sprites ? i_events.spritex : 5'b11111};

  assign joy_data0 = {2'b11, ~i_buttons.b2, ~i_buttons.b1, ~i_buttons.right,
                      ~i_buttons.left, ~i_buttons.down, ~i_buttons.up};

  // Read data selection
  always_comb begin
    rsp_next.data     = 8'hff;   // Open bus
    rsp_next.rom_addr = '0;
    rsp_next.src      = bios;
    case (i_op.port)
      vdp_data:  rsp_next.data = i_vdp_data;
      vdp_ctrl:  rsp_next.data = status;
      joy0:      rsp_next.data = joy_data0;
      joy1:      rsp_next.data = 8'hbf;
      v_count:   rsp_next.data = i_beam.v;
      h_count:   rsp_next.data = i_beam.h;
      mem_plain: begin
        rsp_next.data     = 8'h00;
        rsp_next.rom_addr = i_rom_addr;
        rsp_next.src      = i_src;
      end
      default: ;
    endcase
  end

  // ============================================================
  // Response register
  // ============================================================
  always_ff @(posedge i_cpuClock) begin
    if (!i_n_hard_reset) o_rsp_valid <= 1'b0;
    else if (rsp_load)   o_rsp_valid <= 1'b1;
    else if (i_rsp_ready) o_rsp_valid <= 1'b0;
  end

  always_ff @(posedge i_cpuClock) begin
    if (rsp_load) o_rsp <= rsp_next;
  end

  a_rsp_held: assert property (@(posedge i_cpuClock) disable iff (!i_n_hard_reset)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp));

endmodule

`default_nettype wire

//--- hw/sms_io_top.sv
`timescale 1ns/100ps
`default_nettype none

module sms_io_top import bus_pkg::*; import vdp_pkg::*; #(
  parameter int VRAM_ADDR_BITS = 14
) (
  input  wire               i_cpuClock,
  input  wire               i_n_hard_reset,
  input  wire bus_req_t     i_req,
  input  wire               i_req_valid,
  output logic              o_req_ready,
  output bus_rsp_t          o_rsp,
  output logic              o_rsp_valid,
  input  wire               i_rsp_ready,
  input  wire vdp_event_t   i_events,
  input  wire beam_t        i_beam,
  input  wire joy_buttons_t i_buttons,
  output vdp_cfg_t          o_vdp_cfg,
  output logic              o_vdp_irq_pending
);

  dec_op_t                  op;
  logic                     op_valid, op_ready, op_fire;
  logic [7:0]               vdp_data;
  logic [ROM_ADDR_BITS-1:0] rom_addr;
  mem_src_e                 src;

  // ============================================================
  // Decode, execute, result
  // ============================================================
  port_decode u_decode (
    .i_cpuClock(i_cpuClock), .i_n_hard_reset(i_n_hard_reset),
    .i_req(i_req), .i_req_valid(i_req_valid), .o_req_ready(o_req_ready),
    .o_op(op), .o_op_valid(op_valid), .i_op_ready(op_ready)
  );

  vdp_control #(.VRAM_ADDR_BITS(VRAM_ADDR_BITS)) u_vdp (
    .i_cpuClock(i_cpuClock), .i_n_hard_reset(i_n_hard_reset),
    .i_op(op), .i_fire(op_fire),
    .o_data_rd(vdp_data), .o_cfg(o_vdp_cfg)
  );

  mem_mapper u_mapper (
    .i_cpuClock(i_cpuClock), .i_n_hard_reset(i_n_hard_reset),
    .i_op(op), .i_fire(op_fire),
    .o_rom_addr(rom_addr), .o_src(src)
  );

  read_mux u_result (
    .i_cpuClock(i_cpuClock), .i_n_hard_reset(i_n_hard_reset),
    .i_op(op), .i_op_valid(op_valid), .o_op_ready(op_ready),
    .i_vdp_data(vdp_data), .i_rom_addr(rom_addr), .i_src(src),
    .i_events(i_events), .i_beam(i_beam), .i_buttons(i_buttons),
    .i_irq_en(o_vdp_cfg.frame_irq_en),   // Gate from reg1 bit 5
    .o_rsp(o_rsp), .o_rsp_valid(o_rsp_valid), .i_rsp_ready(i_rsp_ready),
    .o_irq_pending(o_vdp_irq_pending), .o_fire(op_fire)
  );

endmodule

`default_nettype wire

//--- tb/tb_sms_io.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sms_io import bus_pkg::*; import vdp_pkg::*; ();

  localparam logic [7:0] PORT_MEM_CTRL = 8'h3e;
  localparam logic [7:0] PORT_V        = 8'h7e;
  localparam logic [7:0] PORT_H        = 8'h7f;
  localparam logic [7:0] PORT_DATA     = 8'hbe;
  localparam logic [7:0] PORT_CTRL     = 8'hbf;
  localparam logic [7:0] PORT_JOY0     = 8'hdc;
  localparam logic [7:0] PORT_JOY1     = 8'hdd;

  // Cycle budget of reset and of each test in run order
  localparam int TEST_CYCLES = 5 + 110 + 120 + 260 + 80 + 90 + 60;
  localparam int WATCHDOG_NS = TEST_CYCLES * 4 + 1000;

  logic         cpuClock = 1'b0;
  logic         n_hard_reset;
  bus_req_t     req;
  logic         req_valid, req_ready;
  bus_rsp_t     rsp;
  logic         rsp_valid, rsp_ready;
  vdp_event_t   events;
  beam_t        beam;
  joy_buttons_t buttons;
  vdp_cfg_t     vdp_cfg;
  logic         irq_pending;

  logic [31:0] lfsr_state = 32'he9c84d75;
  string       cur_test = "reset";
  int          cycle = 0;
  int          acc_q [$];   // Edge count of each accepted read
  int          lat_q [$];
  bus_rsp_t    rsp_q [$];

  sms_io_top #(.VRAM_ADDR_BITS(14)) uut (
    .i_cpuClock(cpuClock), .i_n_hard_reset(n_hard_reset),
    .i_req(req), .i_req_valid(req_valid), .o_req_ready(req_ready),
    .o_rsp(rsp), .o_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready),
    .i_events(events), .i_beam(beam), .i_buttons(buttons),
    .o_vdp_cfg(vdp_cfg), .o_vdp_irq_pending(irq_pending)
  );

  always #2 cpuClock = ~cpuClock;

  // Bus monitor sampling the pre-edge values
  always @(posedge cpuClock) begin
    cycle <= cycle + 1;
    if (req_valid && req_ready && !req.write) acc_q.push_back(cycle);
    if (rsp_valid && rsp_ready) begin
      rsp_q.push_back(rsp);
      lat_q.push_back(cycle - acc_q.pop_front());
    end
  end

  initial begin
    #WATCHDOG_NS;
    $display("Timeout: the DUT stopped responding before the tests finished");
    abort_run();
  end

  // ============================================================
  // Random source and checks
  // ============================================================

  // Galois form with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'h80200003;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_byte(string what, logic [7:0] exp, logic [7:0] act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h actual %h", cur_test, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_rsp(string what, bus_rsp_t exp, bus_rsp_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h actual %h", cur_test, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cfg(string what, vdp_cfg_t exp, vdp_cfg_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h actual %h", cur_test, what, exp, act);
      abort_run();
    end
  endtask

  // ============================================================
  // Bus helpers
  // ============================================================
  function automatic bus_req_t io_req(logic [7:0] port, logic wr, logic [7:0] data);
    return '{addr: {8'h00, port}, wdata: data, is_io: 1'b1, write: wr};
  endfunction

  function automatic bus_req_t mem_req(logic [15:0] a, logic wr, logic [7:0] data);
    return '{addr: a, wdata: data, is_io: 1'b0, write: wr};
  endfunction

  function automatic bus_rsp_t make_rsp(logic [ROM_ADDR_BITS-1:0] a, mem_src_e s);
    return '{data: 8'h00, rom_addr: a, src: s};
  endfunction

  function automatic vdp_cfg_t make_cfg(vdp_mode_e m, logic [13:0] nb, cb, pb, sab, spb,
                                        logic de, ie, logic [7:0] xs, ys);
    return '{mode: m, name_base: nb, color_base: cb, pattern_base: pb,
             sprite_attr_base: sab, sprite_pattern_base: spb, display_en: de,
             frame_irq_en: ie, x_scroll: xs, y_scroll: ys};
  endfunction

  // Runs from a falling edge to the falling edge after the transfer
  task automatic send(bus_req_t r);
    req       = r;
    req_valid = 1'b1;
    #1;
    while (!req_ready) begin
      @(negedge cpuClock);
      #1;
    end
    @(negedge cpuClock);
    req_valid = 1'b0;
  endtask

  task automatic read_reply(bus_req_t r, output bus_rsp_t got);
    int lat;
    send(r);
    while (rsp_q.size() == 0) @(negedge cpuClock);
    got = rsp_q.pop_front();
    lat = lat_q.pop_front();
    if (lat != 2) begin
      $display("Fail %s: reply latency expected 2 actual %0d", cur_test, lat);
      abort_run();
    end
  endtask

  task automatic io_read(logic [7:0] port, output logic [7:0] data);
    bus_rsp_t got;
    read_reply(io_req(port, 1'b0, 8'h00), got);
    data = got.data;
  endtask

  task automatic set_reg(logic [3:0] idx, logic [7:0] val);
    send(io_req(PORT_CTRL, 1'b1, val));
    send(io_req(PORT_CTRL, 1'b1, {4'b1000, idx}));
  endtask

  task automatic set_bases(logic [7:0] r2, r3, r4, r5, r6);
    set_reg(4'd2, r2);
    set_reg(4'd3, r3);
    set_reg(4'd4, r4);
    set_reg(4'd5, r5);
    set_reg(4'd6, r6);
  endtask

  task automatic set_vdp_addr(logic [13:0] a, logic [1:0] code);
    send(io_req(PORT_CTRL, 1'b1, a[7:0]));
    send(io_req(PORT_CTRL, 1'b1, {code, a[13:8]}));
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic test_mapper();
    logic [13:0] off;
    logic [7:0]  slots [3];
    bus_rsp_t    got;
    cur_test = "mapper";
    for (int r = 0; r < 3; r++) begin
      off = 14'(rand_bits(14));
      read_reply(mem_req({2'(r), off}, 1'b0, 8'h00), got);
      check_rsp("reset slot", make_rsp({8'(r), off}, bios), got);
    end
    send(io_req(PORT_MEM_CTRL, 1'b1, 8'(rand_bits(8)) | 8'h08));  // Cartridge on
    send(mem_req(16'hfffc, 1'b1, 8'(rand_bits(8))));
    for (int r = 0; r < 3; r++) begin
      slots[r] = 8'(rand_bits(8));
      send(mem_req(16'hfffd + 16'(r), 1'b1, slots[r]));
    end
    for (int r = 0; r < 3; r++) begin
      off = 14'(rand_bits(14));
      read_reply(mem_req({2'(r), off}, 1'b0, 8'h00), got);
      check_rsp("new slot", make_rsp({slots[r], off}, cart), got);
    end
    off = 14'(rand_bits(14));
    read_reply(mem_req({2'b11, off}, 1'b0, 8'h00), got);
    check_rsp("work ram", make_rsp(22'({2'b11, off}), ram), got);
  endtask

  task automatic test_vram_round_trip();
    logic [7:0]  data [8];
    logic [13:0] base;
    logic [7:0]  got;
    cur_test = "vram_round_trip";
    base = 14'(rand_bits(14));
    set_vdp_addr(base, 2'b01);
    for (int i = 0; i < 8; i++) begin
      data[i] = 8'(rand_bits(8));
      send(io_req(PORT_DATA, 1'b1, data[i]));
    end
    set_vdp_addr(base, 2'b00);
    for (int i = 0; i < 8; i++) begin
      io_read(PORT_DATA, got);
      check_byte($sformatf("vram[%0d]", i), data[i], got);
    end
  endtask

  task automatic test_registers();
    logic [7:0]  xs, ys, v, got;
    logic [7:0]  cram_data [4];
    logic [5:0]  ca;
    logic [13:0] va;
    cur_test = "registers";
    xs = 8'(rand_bits(8));
    ys = 8'(rand_bits(8));
    set_reg(4'd8, xs);
    set_reg(4'd9, ys);
    set_reg(4'd0, 8'h04);
    set_reg(4'd1, 8'h60);
    set_bases(8'hff, 8'hff, 8'hff, 8'hff, 8'hff);
    @(negedge cpuClock);
    check_cfg("mode4", make_cfg(mode4, 14'h3800, 14'h3fc0, 14'h0000, 14'h3f00, 14'h2000,
                                1'b1, 1'b1, xs, ys), vdp_cfg);
    set_reg(4'd0, 8'h02);
    set_reg(4'd1, 8'h40);
    set_bases(8'h06, 8'h80, 8'h04, 8'h36, 8'h07);
    @(negedge cpuClock);
    check_cfg("graphic2", make_cfg(graphic2, 14'h1800, 14'h2000, 14'h2000, 14'h1b00, 14'h3800,
                                   1'b1, 1'b0, xs, ys), vdp_cfg);
    set_reg(4'd0, 8'h00);
    set_reg(4'd1, 8'h10);
    set_bases(8'h0e, 8'h2c, 8'h03, 8'h7f, 8'h05);
    @(negedge cpuClock);
    check_cfg("mode1", make_cfg(mode1, 14'h3800, 14'h0b00, 14'h1800, 14'h3f00, 14'h2800,
                                1'b0, 1'b0, xs, ys), vdp_cfg);
    set_reg(4'd1, 8'h18);  // M3 outranks M1
    @(negedge cpuClock);
    check_cfg("mode3", make_cfg(mode3, 14'h3800, 14'h0b00, 14'h1800, 14'h3f00, 14'h2800,
                                1'b0, 1'b0, xs, ys), vdp_cfg);

    // CRAM at the same low address as a VRAM byte
    ca = 6'(rand_bits(6));
    va = {8'(rand_bits(8)), ca};
    v  = 8'(rand_bits(8));
    set_vdp_addr(va, 2'b01);
    send(io_req(PORT_DATA, 1'b1, v));
    send(io_req(PORT_CTRL, 1'b1, {2'b00, ca}));
    send(io_req(PORT_CTRL, 1'b1, 8'hc0));
    for (int i = 0; i < 4; i++) begin
      cram_data[i] = 8'(rand_bits(8));
      send(io_req(PORT_DATA, 1'b1, cram_data[i]));
    end
    send(io_req(PORT_CTRL, 1'b1, {2'b00, ca}));
    send(io_req(PORT_CTRL, 1'b1, 8'h8f));  // Index 15 acts as a CRAM address
    for (int i = 0; i < 4; i++) begin
      io_read(PORT_DATA, got);
      check_byte($sformatf("cram[%0d]", i), cram_data[i], got);
    end
    set_vdp_addr(va, 2'b00);
    io_read(PORT_DATA, got);
    check_byte("vram under cram", v, got);
  endtask

  task automatic test_status();
    logic [7:0] got;
    logic [4:0] sx;
    cur_test = "status";
    set_reg(4'd1, 8'h00);
    events.frame_irq        = 1'b1;
    events.sprite_collision = 1'b1;
    @(negedge cpuClock);
    events.frame_irq        = 1'b0;
    events.sprite_collision = 1'b0;
    check_byte("irq masked", 8'h00, {7'b0, irq_pending});
    set_reg(4'd1, 8'h20);
    @(negedge cpuClock);
    check_byte("irq enabled", 8'h01, {7'b0, irq_pending});
    io_read(PORT_CTRL, got);
    check_byte("status set", 8'hbf, got);
    check_byte("irq after read", 8'h00, {7'b0, irq_pending});
    sx = 5'(rand_bits(5));
    events.too_many_sprites = 1'b1;
    events.spritex          = sx;
    io_read(PORT_CTRL, got);
    check_byte("status cleared", {3'b010, sx}, got);
    events = '0;
  endtask

  task automatic test_inputs();
    logic [7:0] got;
    logic [7:0] exp;
    logic [5:0] raw;
    cur_test = "inputs";
    for (int i = 0; i < 3; i++) begin
      raw     = 6'(rand_bits(6));
      buttons = raw;
      beam    = 16'(rand_bits(16));
      // Port order b2..up runs opposite to the packed order up..b2
      exp = 8'hc0;
      for (int b = 0; b < 6; b++) exp[b] = !raw[5 - b];
      io_read(PORT_JOY0, got);
      check_byte("joy0", exp, got);
      io_read(PORT_JOY1, got);
      check_byte("joy1", 8'hbf, got);
      io_read(PORT_V, got);
      check_byte("v counter", beam.v, got);
      io_read(PORT_H, got);
      check_byte("h counter", beam.h, got);
    end
  endtask

  task automatic test_back_pressure();
    logic [15:0] addrs [4];
    bus_rsp_t    got;
    cur_test = "back_pressure";
    for (int i = 0; i < 4; i++) addrs[i] = {2'b11, 14'(rand_bits(14))};
    rsp_ready = 1'b0;
    fork
      for (int i = 0; i < 4; i++) send(mem_req(addrs[i], 1'b0, 8'h00));
      begin
        repeat (4) @(negedge cpuClock);
        #1;
        check_byte("req_ready low", 8'h00, {7'b0, req_ready});
        check_byte("reply held", 8'h01, {7'b0, rsp_valid});
        check_rsp("held reply", make_rsp(22'(addrs[0]), ram), rsp);
        @(negedge cpuClock);
        rsp_ready = 1'b1;
      end
    join
    while (rsp_q.size() < 4) @(negedge cpuClock);
    repeat (3) @(negedge cpuClock);
    check_byte("reply count", 8'd4, 8'(rsp_q.size()));
    for (int i = 0; i < 4; i++) begin
      got = rsp_q.pop_front();
      check_rsp($sformatf("reply %0d", i), make_rsp(22'(addrs[i]), ram), got);
    end
    lat_q.delete();
  endtask

  // ============================================================
  // Sequence
  // ============================================================
  initial begin
    n_hard_reset = 1'b0;
    req          = '0;
    req_valid    = 1'b0;
    rsp_ready    = 1'b1;
    events       = '0;
    beam         = '0;
    buttons      = '0;
    repeat (5) @(negedge cpuClock);
    n_hard_reset = 1'b1;
    check_byte("req_ready", 8'h01, {7'b0, req_ready});
    check_byte("rsp_valid", 8'h00, {7'b0, rsp_valid});
    check_byte("irq_pending", 8'h00, {7'b0, irq_pending});

    test_mapper();
    test_vram_round_trip();
    test_registers();
    test_status();
    test_inputs();
    test_back_pressure();

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sms_io_top.f
hw/bus_pkg.sv
hw/vdp_pkg.sv
hw/port_decode.sv
hw/vdp_control.sv
hw/mem_mapper.sv
hw/read_mux.sv
hw/sms_io_top.sv
tb/tb_sms_io.sv
